// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_imager
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
FLAGS     ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the simulation, pass is found in $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f filelist.f
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: filelist.f
+incdir+.
imager_pkg.sv
raster_if.sv
raster_timing.sv
noise_lfsr.sv
pattern_gen.sv
frame_monitor.sv
imager_top.sv
tb_imager.sv

// File: frame_monitor.sv
`timescale 1ns/1ps

module frame_monitor (
   input  logic                   clk,
   input  logic                   reset_n,
   input  imager_pkg::pixel_t     dat,
   input  logic                   fv,
   input  logic                   lv,
   output logic                   stats_valid,
   output imager_pkg::row_t       frame_lines,
   output imager_pkg::col_t       line_pixels,
   output imager_pkg::frame_sum_t frame_sum
);

   logic                   fv_d;
   logic                   lv_d;
   logic                   fv_rise;
   logic                   fv_fall;
   logic                   lv_rise;
   imager_pkg::row_t       line_cnt;
   imager_pkg::col_t       pix_cnt;
   imager_pkg::frame_sum_t sum_acc;
   imager_pkg::frame_sum_t dat_ext;

   assign fv_rise = fv && !fv_d;
   assign fv_fall = !fv && fv_d;
   assign lv_rise = lv && !lv_d;
   assign dat_ext = imager_pkg::frame_sum_t'(dat);

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         fv_d     <= 1'b0;
         lv_d     <= 1'b0;
         line_cnt <= '0;
         pix_cnt  <= '0;
         sum_acc  <= '0;
      end else begin
         fv_d <= fv;
         lv_d <= lv;

         // lv may rise together with fv when there is no front porch
         if (fv_rise) begin
            line_cnt <= lv ? imager_pkg::row_t'(1) : '0;
            sum_acc  <= dat_ext;
         end else if (fv) begin
            if (lv_rise) begin
               line_cnt <= line_cnt + 1'b1;
            end
            sum_acc <= sum_acc + dat_ext;
         end

         // pixel count restarts on every line and holds through blanking
         if (lv_rise) begin
            pix_cnt <= imager_pkg::col_t'(1);
         end else if (lv) begin
            pix_cnt <= pix_cnt + 1'b1;
         end
      end
   end

   // publish at the end of the frame
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         stats_valid <= 1'b0;
         frame_lines <= '0;
         line_pixels <= '0;
         frame_sum   <= '0;
      end else begin
         stats_valid <= fv_fall;
         if (fv_fall) begin
            frame_lines <= line_cnt;
            line_pixels <= pix_cnt;
            frame_sum   <= sum_acc;
         end
      end
   end

   a_stats_single: assert property (
      @(posedge clk) disable iff (!reset_n)
      stats_valid |=> !stats_valid
   );

   // incoming video never shows lv outside a frame
   a_lv_inside_fv: assert property (
      @(posedge clk) disable iff (!reset_n)
      lv |-> fv
   );

endmodule

// File: imager_consts.svh
`ifndef IMAGER_CONSTS_SVH
`define IMAGER_CONSTS_SVH

// pixel value width
`define IMG_DATA_WIDTH 10

// row count and row configuration width
`define IMG_ROWS_WIDTH 12

// column count and column configuration width
`define IMG_COLS_WIDTH 12

// free running frame counter
`define IMG_FRAME_WIDTH 16

// per-frame pixel sum, wraps on overflow
`define IMG_SUM_WIDTH 32

`endif

// File: imager_pkg.sv
package imager_pkg;

`include "imager_consts.svh"

   typedef logic [`IMG_DATA_WIDTH-1:0] pixel_t;

   typedef logic [`IMG_ROWS_WIDTH-1:0] row_t;
   typedef logic [`IMG_COLS_WIDTH-1:0] col_t;

   // raster counters carry one extra bit so active + virtual cannot overflow
   typedef logic [`IMG_ROWS_WIDTH:0] row_pos_t;
   typedef logic [`IMG_COLS_WIDTH:0] col_pos_t;

   typedef logic [`IMG_FRAME_WIDTH-1:0] frame_num_t;
   typedef logic [`IMG_SUM_WIDTH-1:0] frame_sum_t;

   // noise generator state and seed
   typedef logic [31:0] seed_t;

   // codes 6 and 7 are unused and produce black
   typedef enum logic [2:0] {
      PAT_NOISE       = 3'd0,
      PAT_ROW_RAMP    = 3'd1,
      PAT_COL_RAMP    = 3'd2,
      PAT_DIAG        = 3'd3,
      PAT_FRAME_CONST = 3'd4,
      PAT_FRAME_DIAG  = 3'd5
   } pattern_mode_e;

endpackage

// File: imager_top.sv
`timescale 1ns/1ps

module imager_top (
   input  logic                   clk,
   input  logic                   reset_n,
   input  logic                   enable,
   input  logic [2:0]             mode,
   input  imager_pkg::row_t       num_active_rows,
   input  imager_pkg::row_t       num_virtual_rows,
   input  imager_pkg::col_t       num_active_cols,
   input  imager_pkg::col_t       num_virtual_cols,
   input  imager_pkg::seed_t      noise_seed,
   output imager_pkg::pixel_t     dat,
   output logic                   fv,
   output logic                   lv,
   output logic                   stats_valid,
   output imager_pkg::row_t       frame_lines,
   output imager_pkg::col_t       line_pixels,
   output imager_pkg::frame_sum_t frame_sum
);

   imager_pkg::pattern_mode_e mode_sel;
   imager_pkg::seed_t         noise;

   // unused codes pass through and select black in the generator
   assign mode_sel = imager_pkg::pattern_mode_e'(mode);

   raster_if raster ();

   raster_timing raster_timing_i (
      .clk              (clk),
      .reset_n          (reset_n),
      .enable           (enable),
      .num_active_rows  (num_active_rows),
      .num_virtual_rows (num_virtual_rows),
      .num_active_cols  (num_active_cols),
      .num_virtual_cols (num_virtual_cols),
      .raster           (raster.source)
   );

   noise_lfsr noise_lfsr_i (
      .clk        (clk),
      .reset_n    (reset_n),
      .noise_seed (noise_seed),
      .raster     (raster.sink),
      .noise      (noise)
   );

   pattern_gen pattern_gen_i (
      .clk     (clk),
      .reset_n (reset_n),
      .enable  (enable),
      .mode    (mode_sel),
      .noise   (noise),
      .raster  (raster.sink),
      .dat     (dat),
      .fv      (fv),
      .lv      (lv)
   );

   frame_monitor frame_monitor_i (
      .clk         (clk),
      .reset_n     (reset_n),
      .dat         (dat),
      .fv          (fv),
      .lv          (lv),
      .stats_valid (stats_valid),
      .frame_lines (frame_lines),
      .line_pixels (line_pixels),
      .frame_sum   (frame_sum)
   );

endmodule

// File: noise_lfsr.sv
`timescale 1ns/1ps

module noise_lfsr (
   input  logic              clk,
   input  logic              reset_n,
   input  imager_pkg::seed_t noise_seed,
   raster_if.sink            raster,
   output imager_pkg::seed_t noise
);

   imager_pkg::seed_t state;
   logic              feedback;

   // xnor taps 32, 22, 2, 1
   assign feedback = ~(state[31] ^ state[21] ^ state[1] ^ state[0]);

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         state <= 32'd1;
      end else if (!raster.fv_next) begin
         // restart the sequence in vertical blanking only for a fixed seed
         if (|noise_seed) begin
            state <= noise_seed;
         end
      end else if (raster.lv_next) begin
         state <= {state[30:0], feedback};
      end
   end

   assign noise = state;

endmodule

// File: pattern_gen.sv
`timescale 1ns/1ps

module pattern_gen (
   input  logic                      clk,
   input  logic                      reset_n,
   input  logic                      enable,
   input  imager_pkg::pattern_mode_e mode,
   input  imager_pkg::seed_t         noise,
   raster_if.sink                    raster,
   output imager_pkg::pixel_t        dat,
   output logic                      fv,
   output logic                      lv
);

   imager_pkg::pixel_t row_pix;
   imager_pkg::pixel_t col_pix;
   imager_pkg::pixel_t frame_pix;
   imager_pkg::pixel_t noise_pix;
   imager_pkg::pixel_t dat_sel;

   // every pattern is taken modulo the pixel width
   assign row_pix   = imager_pkg::pixel_t'(raster.row);
   assign col_pix   = imager_pkg::pixel_t'(raster.col);
   assign frame_pix = imager_pkg::pixel_t'(raster.frame_num);
   assign noise_pix = imager_pkg::pixel_t'(noise);

   always_comb begin
      case (mode)
         imager_pkg::PAT_NOISE: begin
            dat_sel = noise_pix;
         end
         imager_pkg::PAT_ROW_RAMP: begin
            dat_sel = row_pix;
         end
         imager_pkg::PAT_COL_RAMP: begin
            dat_sel = col_pix;
         end
         imager_pkg::PAT_DIAG: begin
            dat_sel = row_pix + col_pix;
         end
         imager_pkg::PAT_FRAME_CONST: begin
            dat_sel = frame_pix;
         end
         imager_pkg::PAT_FRAME_DIAG: begin
            dat_sel = frame_pix + row_pix + col_pix;
         end
         default: begin
            dat_sel = '0;
         end
      endcase
   end

   // video leaves one cycle behind the raster position
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         dat <= '0;
         fv  <= 1'b0;
         lv  <= 1'b0;
      end else if (!enable) begin
         dat <= '0;
         fv  <= 1'b0;
         lv  <= 1'b0;
      end else begin
         fv  <= raster.fv_next;
         lv  <= raster.lv_next;
         dat <= raster.lv_next ? dat_sel : '0;
      end
   end

   // blanking is always black on the wire
   a_dat_zero_blank: assert property (
      @(posedge clk) disable iff (!reset_n)
      !lv |-> (dat == '0)
   );

endmodule

// File: raster_if.sv
`timescale 1ns/1ps

// raster position and decoded timing, one producer and several consumers
interface raster_if;

   // registered position inside the full raster
   imager_pkg::row_pos_t row;
   imager_pkg::col_pos_t col;

   imager_pkg::frame_num_t frame_num;

   // combinational decode of the current position
   logic fv_next;
   logic lv_next;

   modport source (
      output row,
      output col,
      output frame_num,
      output fv_next,
      output lv_next
   );

   modport sink (
      input row,
      input col,
      input frame_num,
      input fv_next,
      input lv_next
   );

endinterface

// File: raster_timing.sv
`timescale 1ns/1ps

module raster_timing (
   input  logic                clk,
   input  logic                reset_n,
   input  logic                enable,
   input  imager_pkg::row_t    num_active_rows,
   input  imager_pkg::row_t    num_virtual_rows,
   input  imager_pkg::col_t    num_active_cols,
   input  imager_pkg::col_t    num_virtual_cols,
   raster_if.source            raster
);

   imager_pkg::row_pos_t   row_q;
   imager_pkg::row_pos_t   next_row;
   imager_pkg::row_pos_t   total_rows;
   imager_pkg::col_pos_t   col_q;
   imager_pkg::col_pos_t   next_col;
   imager_pkg::col_pos_t   total_cols;
   imager_pkg::col_t       hblank_fp;
   imager_pkg::col_pos_t   lv_end;
   imager_pkg::frame_num_t frame_q;
   logic                   fv_dec;
   logic                   lv_dec;

   assign next_row   = row_q + 1'b1;
   assign next_col   = col_q + 1'b1;
   assign total_rows = {1'b0, num_active_rows} + {1'b0, num_virtual_rows};
   assign total_cols = {1'b0, num_active_cols} + {1'b0, num_virtual_cols};

   // half of the horizontal blanking sits before the active pixels
   assign hblank_fp = num_virtual_cols >> 1;
   assign lv_end    = {1'b0, num_active_cols} + {1'b0, hblank_fp};

   // vertical blanking follows the active rows
   assign fv_dec = (row_q < {1'b0, num_active_rows});
   assign lv_dec = fv_dec && (col_q >= {1'b0, hblank_fp}) && (col_q < lv_end);

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         row_q   <= '0;
         col_q   <= '0;
         frame_q <= '0;
      end else if (!enable) begin
         // park at the top left corner, frame count is kept
         row_q <= '0;
         col_q <= '0;
      end else if (next_col >= total_cols) begin
         col_q <= '0;
         if (next_row >= total_rows) begin
            row_q   <= '0;
            frame_q <= frame_q + 1'b1;
         end else begin
            row_q <= next_row;
         end
      end else begin
         col_q <= next_col;
      end
   end

   assign raster.row       = row_q;
   assign raster.col       = col_q;
   assign raster.frame_num = frame_q;
   assign raster.fv_next   = fv_dec;
   assign raster.lv_next   = lv_dec;

   // an active pixel is always inside an active row
   a_lv_inside_fv: assert property (
      @(posedge clk) disable iff (!reset_n)
      lv_dec |-> fv_dec
   );

   // column counter never reaches the line length while running
   a_col_in_range: assert property (
      @(posedge clk) disable iff (!reset_n)
      enable |-> (col_q < total_cols)
   );

endmodule

// File: tb_imager.sv
`timescale 1ns/1ps

module tb_imager;

   localparam int TIMEOUT_CYCLES  = 1000;
   localparam int EXPECTED_FRAMES = 25;

   logic                   clk;
   logic                   reset_n;
   logic                   enable;
   logic [2:0]             mode;
   imager_pkg::row_t       num_active_rows;
   imager_pkg::row_t       num_virtual_rows;
   imager_pkg::col_t       num_active_cols;
   imager_pkg::col_t       num_virtual_cols;
   imager_pkg::seed_t      noise_seed;
   imager_pkg::pixel_t     dat;
   logic                   fv;
   logic                   lv;
   logic                   stats_valid;
   imager_pkg::row_t       frame_lines;
   imager_pkg::col_t       line_pixels;
   imager_pkg::frame_sum_t frame_sum;

   // reference model state, owned by the monitor process
   imager_pkg::frame_num_t exp_frame = '0;
   imager_pkg::seed_t      model_lfsr = 32'd1;
   imager_pkg::frame_sum_t model_sum = '0;
   imager_pkg::pixel_t     exp_pix;
   int                     row_idx = 0;
   int                     col_idx = 0;
   logic                   fv_prev = 1'b0;
   logic                   lv_prev = 1'b0;
   logic                   partial_frame = 1'b0;
   logic [31:0]            rng = 32'd59;
   int                     frames_checked = 0;
   int                     pixel_errors = 0;
   int                     count_errors = 0;
   int                     sum_errors = 0;
   int                     other_errors = 0;

   imager_top imager_top_i (.*);

   initial begin
      clk = 1'b0;
      forever begin
         #50 clk = ~clk;
      end
   end

   // shift left, feedback is the xnor of taps 32, 22, 2 and 1
   function automatic imager_pkg::seed_t lfsr_step(input imager_pkg::seed_t s);
      return {s[30:0], ~(s[31] ^ s[21] ^ s[1] ^ s[0])};
   endfunction

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   // expected pixel at a raster position, truncated to the pixel width
   function automatic imager_pkg::pixel_t ref_pixel(input logic [2:0] m, input int row,
         input int col, input imager_pkg::frame_num_t frame, input imager_pkg::seed_t lfsr);
      int unsigned v;
      case (m)
         imager_pkg::PAT_NOISE:       v = lfsr;
         imager_pkg::PAT_ROW_RAMP:    v = row;
         imager_pkg::PAT_COL_RAMP:    v = col;
         imager_pkg::PAT_DIAG:        v = row + col;
         imager_pkg::PAT_FRAME_CONST: v = 32'(frame);
         imager_pkg::PAT_FRAME_DIAG:  v = 32'(frame) + row + col;
         default:                     v = 0;
      endcase
      return imager_pkg::pixel_t'(v);
   endfunction

   task automatic check_pixel(input imager_pkg::pixel_t got, input imager_pkg::pixel_t expected,
         input string what);
      if (got !== expected) begin
         pixel_errors++;
         $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, expected);
      end
   endtask

   task automatic check_count(input imager_pkg::row_t got, input imager_pkg::row_t expected,
         input string what);
      if (got !== expected) begin
         count_errors++;
         $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, expected);
      end
   endtask

   task automatic check_sum(input imager_pkg::frame_sum_t got,
         input imager_pkg::frame_sum_t expected, input string what);
      if (got !== expected) begin
         sum_errors++;
         $display("** Error at %0t: %s is %h, expected %h", $time, what, got, expected);
      end
   endtask

   task automatic finish_run();
      $display("frames checked %0d, errors: pixel %0d, count %0d, sum %0d, other %0d",
               frames_checked, pixel_errors, count_errors, sum_errors, other_errors);
      if (pixel_errors + count_errors + sum_errors + other_errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   endtask

   // waits for a stats report, or for lv to rise when for_stats is low
   task automatic wait_event(input logic for_stats);
      int   cycles;
      logic hit;
      logic prev;
      cycles = 0;
      hit    = 1'b0;
      prev   = lv;
      while (!hit && cycles < TIMEOUT_CYCLES) begin
         @(negedge clk);
         cycles++;
         hit  = for_stats ? stats_valid : (lv && !prev);
         prev = lv;
      end
      if (!hit) begin
         other_errors++;
         $display("timed out after %0d cycles waiting for %s", cycles,
                  for_stats ? "stats_valid" : "lv to rise");
         finish_run();
      end
   endtask

   // called where stats_valid was seen, which is two cycles into vertical blanking;
   // enable drops at the raster wrap so the raster parks at the start of a frame
   task automatic next_config(input logic [2:0] m, input imager_pkg::row_t rows,
         input imager_pkg::col_t cols, input imager_pkg::seed_t seed);
      int gap;
      gap = int'(num_virtual_rows) * int'(num_active_cols + num_virtual_cols) - 2;
      repeat (gap) @(posedge clk);
      enable <= 1'b0;
      @(posedge clk);
      mode            <= m;
      num_active_rows <= rows;
      num_active_cols <= cols;
      noise_seed      <= seed;
      @(posedge clk);
      enable <= 1'b1;
   endtask

   always @(negedge clk) begin
      if (reset_n) begin
         if (fv && !fv_prev) begin
            row_idx   = -1;
            model_sum = '0;
         end
         if (lv && !lv_prev) begin
            row_idx++;
            col_idx = int'(num_virtual_cols >> 1);
         end
         if (lv) begin
            exp_pix = ref_pixel(mode, row_idx, col_idx, exp_frame, model_lfsr);
            check_pixel(dat, exp_pix, $sformatf("dat at row %0d col %0d", row_idx, col_idx));
            model_sum  += imager_pkg::frame_sum_t'(exp_pix);
            model_lfsr  = lfsr_step(model_lfsr);
            col_idx++;
         end
         // report of an interrupted frame is dropped, frame number stays
         if (stats_valid && !partial_frame) begin
            check_count(frame_lines, num_active_rows, "frame_lines");
            check_count(line_pixels, num_active_cols, "line_pixels");
            check_sum(frame_sum, model_sum, "frame_sum");
            exp_frame++;
            frames_checked++;
            // vertical blanking reloads a non-zero seed
            if (noise_seed != '0) begin
               model_lfsr = noise_seed;
            end
         end
         fv_prev = fv;
         lv_prev = lv;
      end
   end

   initial begin
      imager_pkg::frame_sum_t first_sum;
      reset_n          = 1'b0;
      enable           = 1'b0;
      mode             = imager_pkg::PAT_COL_RAMP;
      num_active_rows  = 12'd5;
      num_virtual_rows = 12'd2;
      num_active_cols  = 12'd8;
      num_virtual_cols = 12'd4;
      noise_seed       = 32'h1d87_2b41;
      repeat (5) @(posedge clk);
      reset_n <= 1'b1;
      @(negedge clk);
      check_pixel(dat, '0, "dat after reset");
      check_count(imager_pkg::row_t'({stats_valid, fv, lv}), '0, "stats_valid fv lv after reset");
      check_count(frame_lines, '0, "frame_lines after reset");
      check_count(line_pixels, '0, "line_pixels after reset");
      check_sum(frame_sum, '0, "frame_sum after reset");
      @(posedge clk);
      enable <= 1'b1;
      wait_event(1'b1);
      wait_event(1'b1);
      // deterministic patterns, two frames each
      for (int m = 1; m <= 5; m++) begin
         next_config(3'(m), num_active_rows, num_active_cols, noise_seed);
         wait_event(1'b1);
         wait_event(1'b1);
      end
      // fixed seed, both frames start from the same state
      next_config(imager_pkg::PAT_NOISE, num_active_rows, num_active_cols, noise_seed);
      wait_event(1'b1);
      first_sum = frame_sum;
      wait_event(1'b1);
      check_sum(frame_sum, first_sum, "noise frame_sum of second fixed seed frame");
      next_config(imager_pkg::PAT_NOISE, num_active_rows, num_active_cols, '0);
      wait_event(1'b1);
      wait_event(1'b1);
      // drop enable in the second active line
      next_config(imager_pkg::PAT_FRAME_DIAG, num_active_rows, num_active_cols, '0);
      wait_event(1'b0);
      wait_event(1'b0);
      @(posedge clk);
      enable        <= 1'b0;
      partial_frame <= 1'b1;
      @(posedge clk);
      @(negedge clk);
      check_pixel(dat, '0, "dat after disable");
      check_count(imager_pkg::row_t'({fv, lv}), '0, "fv lv after disable");
      wait_event(1'b1);
      @(posedge clk);
      partial_frame <= 1'b0;
      enable        <= 1'b1;
      wait_event(1'b1);
      for (int i = 0; i < 4; i++) begin
         rng = xorshift32(rng);
         next_config(3'(1 + rng % 5), 12'(4 + (rng >> 8) % 3), 12'(6 + (rng >> 16) % 5), '0);
         wait_event(1'b1);
         wait_event(1'b1);
      end
      @(posedge clk);
      if (frames_checked != EXPECTED_FRAMES) begin
         other_errors++;
         $display("%0d complete frames were checked instead of %0d", frames_checked,
                  EXPECTED_FRAMES);
      end
      finish_run();
   end

endmodule
